/* common/cpuPkg.sv */
package cpuPkg;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opXori  = 6'h0e,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnSra = 6'h03,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnXor = 6'h26,
        fnNor = 6'h27,
        fnSlt = 6'h2a
    } functT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluNor = 4'd5,
        aluSlt = 4'd6,
        aluSll = 4'd7,
        aluSrl = 4'd8,
        aluSra = 4'd9
    } aluOpT;

    typedef struct packed {
        opcodeT     opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } rFieldsT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFieldsT;

    typedef struct packed {
        opcodeT      opcode;
        logic [25:0] target26;
    } jFieldsT;

    // one instruction word, three views
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
        jFieldsT j;
    } instrT;

    typedef struct packed {
        aluOpT aluOp;
        logic  regWrite;
        logic  memWrite;
        logic  shamtToA;    // alu A from shamt
        logic  memToReg;
        logic  immToB;      // alu B from immediate
        logic  writeToRd;
        logic  zeroExtend;
        logic  jal;
        logic  jump;
        logic  jumpReg;
        logic  takeBranch;
    } ctrlT;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbPortT;

    typedef struct packed {
        logic       exRegWrite;
        logic [4:0] exAddr;
        logic       exMemToReg;  // EX holds a load
        logic       memRegWrite;
        logic [4:0] memAddr;
    } hazardSrcT;

    typedef struct packed {
        logic [31:0] jumpOrBranchPc;
        logic [31:0] regRtOrZero;
        logic [31:0] regRsOrPc4;
        logic [31:0] immediate;
        logic [4:0]  regWriteAddr;
        ctrlT        ctrl;
        logic        stall;
    } idOutT;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

endpackage

/* regFile/regFile.sv */
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  wbPortT      wb,
    input  logic [4:0]  dbgAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    output logic [31:0] dbgData
);

    logic [31:0] regs [1:31];  // $0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.regWrite && wb.addr != 5'd0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // write-first read, so a value written this cycle is seen now
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (wb.regWrite && wb.addr == addr) begin
            value = wb.data;  // bypass
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rsData  = readPort(rsAddr);
        rtData  = readPort(rtAddr);
        dbgData = readPort(dbgAddr);
    end

    // a committed write reads back next cycle unless a newer write bypasses it
    writeReadBack: assert property (@(posedge clk) disable iff (!rstN)
        (wb.regWrite && wb.addr != 5'd0)
        |=> (rsAddr != $past(wb.addr) || (wb.regWrite && wb.addr == rsAddr)
            || rsData == $past(wb.data)));

endmodule

/* regFile/regDebugApb.sv */
`timescale 1ns/1ps

module regDebugApb import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  apbReqT      apbReq,
    output apbRspT      apbRsp,
    output logic [4:0]  dbgAddr,
    input  logic [31:0] dbgData
);

    logic setupSeen;  // last cycle was a setup phase
    logic access;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            setupSeen <= 1'b0;
        end else begin
            setupSeen <= apbReq.psel && !apbReq.penable;
        end
    end

    assign access  = apbReq.psel && apbReq.penable && setupSeen;
    assign dbgAddr = apbReq.paddr[6:2];  // word index, bit 7 ignored

    // no wait states, writes are refused
    always_comb begin
        apbRsp = '0;
        if (access) begin
            apbRsp.pready  = 1'b1;
            apbRsp.pslverr = apbReq.pwrite;
            apbRsp.prdata  = apbReq.pwrite ? '0 : dbgData;
        end
    end

    enableAfterSelect: assert property (@(posedge clk) disable iff (!rstN)
        apbReq.penable |-> $past(apbReq.psel));

endmodule

/* idStage/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  instrT     instr,
    input  logic      rsEqualRt,
    input  hazardSrcT hazard,
    output ctrlT      ctrl,
    output logic      stall
);

    ctrlT base;       // decode before bubble masking
    logic readsRs;
    logic readsRt;
    logic earlyUse;   // operand needed here: beq, bne, jr

    // a source conflicts with a later-stage writer that cannot be waited out in EX
    function automatic logic srcHazard(input logic [4:0] src, input hazardSrcT hz,
                                       input logic early);
        logic exHit;
        logic memHit;
        exHit  = hz.exRegWrite && hz.exAddr == src && (hz.exMemToReg || early);
        memHit = hz.memRegWrite && hz.memAddr == src && early;
        return src != 5'd0 && (exHit || memHit);
    endfunction

    always_comb begin
        base     = '0;
        readsRs  = 1'b0;
        readsRt  = 1'b0;
        earlyUse = 1'b0;
        case (instr.r.opcode)
            opRType: begin
                base.regWrite  = 1'b1;
                base.writeToRd = 1'b1;
                readsRs        = 1'b1;
                readsRt        = 1'b1;
                case (instr.r.funct)
                    fnAdd: base.aluOp = aluAdd;
                    fnSub: base.aluOp = aluSub;
                    fnAnd: base.aluOp = aluAnd;
                    fnOr:  base.aluOp = aluOr;
                    fnXor: base.aluOp = aluXor;
                    fnNor: base.aluOp = aluNor;
                    fnSlt: base.aluOp = aluSlt;
                    fnSll, fnSrl, fnSra: begin
                        base.shamtToA = 1'b1;
                        readsRs       = 1'b0;  // shifts only take rt
                        if (instr.r.funct == fnSll) begin
                            base.aluOp = aluSll;
                        end else if (instr.r.funct == fnSrl) begin
                            base.aluOp = aluSrl;
                        end else begin
                            base.aluOp = aluSra;
                        end
                    end
                    fnJr: begin
                        base            = '0;
                        base.jumpReg    = 1'b1;
                        base.takeBranch = 1'b1;
                        readsRt         = 1'b0;
                        earlyUse        = 1'b1;
                    end
                    default: begin
                        base    = '0;
                        readsRs = 1'b0;
                        readsRt = 1'b0;
                    end
                endcase
            end
            opAddi, opSlti, opAndi, opOri, opXori, opLw: begin
                base.regWrite = 1'b1;
                base.immToB   = 1'b1;
                readsRs       = 1'b1;
                case (instr.r.opcode)
                    opSlti: base.aluOp = aluSlt;
                    opAndi: base.aluOp = aluAnd;
                    opOri:  base.aluOp = aluOr;
                    opXori: base.aluOp = aluXor;
                    default: base.aluOp = aluAdd;  // addi, lw
                endcase
                base.zeroExtend = instr.r.opcode inside {opAndi, opOri, opXori};
                base.memToReg   = instr.r.opcode == opLw;
            end
            opSw: begin
                base.aluOp    = aluAdd;
                base.memWrite = 1'b1;
                base.immToB   = 1'b1;
                readsRs       = 1'b1;
                readsRt       = 1'b1;
            end
            opBeq, opBne: begin
                base.aluOp      = aluSub;
                base.takeBranch = (instr.r.opcode == opBeq) ? rsEqualRt : !rsEqualRt;
                readsRs         = 1'b1;
                readsRt         = 1'b1;
                earlyUse        = 1'b1;
            end
            opJ: begin
                base.jump       = 1'b1;
                base.takeBranch = 1'b1;
            end
            opJal: begin
                base.jal        = 1'b1;
                base.jump       = 1'b1;
                base.takeBranch = 1'b1;
                base.regWrite   = 1'b1;  // $ra
            end
            default: base = '0;
        endcase
    end

    assign stall = (readsRs && srcHazard(instr.r.rs, hazard, earlyUse))
                || (readsRt && srcHazard(instr.r.rt, hazard, earlyUse));

    always_comb begin
        ctrl = base;
        if (stall) begin
            ctrl.regWrite   = 1'b0;  // bubble
            ctrl.memWrite   = 1'b0;
            ctrl.takeBranch = 1'b0;
        end
    end

endmodule

/* idStage/idStage.sv */
`timescale 1ns/1ps

module idStage import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] pc4,
    input  instrT       instr,
    input  wbPortT      wb,
    input  hazardSrcT   hazard,
    input  logic [4:0]  dbgAddr,
    output logic [31:0] dbgData,
    output idOutT       idOut
);

    logic [31:0] rsData;
    logic [31:0] rtData;
    logic        rsEqualRt;
    ctrlT        ctrl;
    logic        stall;
    logic [31:0] signImm;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [4:0]  destAddr;

    controlUnit controlUnit_i (
        .instr     (instr),
        .rsEqualRt (rsEqualRt),
        .hazard    (hazard),
        .ctrl      (ctrl),
        .stall     (stall)
    );

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rsAddr  (instr.i.rs),
        .rtAddr  (instr.i.rt),
        .wb      (wb),
        .dbgAddr (dbgAddr),
        .rsData  (rsData),
        .rtData  (rtData),
        .dbgData (dbgData)
    );

    // branch decided here, not in EX
    assign rsEqualRt = rsData == rtData;

    assign signImm      = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign branchTarget = pc4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {pc4[31:28], instr.j.target26, 2'b00};

    assign destAddr = ctrl.writeToRd ? instr.r.rd : instr.i.rt;

    always_comb begin
        if (ctrl.jumpReg) begin
            idOut.jumpOrBranchPc = rsData;
        end else if (ctrl.jump) begin
            idOut.jumpOrBranchPc = jumpTarget;
        end else begin
            idOut.jumpOrBranchPc = branchTarget;
        end

        // jal sends pc4 down the alu path so EX computes the link value
        idOut.regRtOrZero  = ctrl.jal ? '0 : rtData;
        idOut.regRsOrPc4   = ctrl.jal ? pc4 : rsData;
        idOut.regWriteAddr = ctrl.jal ? 5'd31 : destAddr;

        idOut.immediate = ctrl.zeroExtend ? {16'h0000, instr.i.imm16} : signImm;
        idOut.ctrl      = ctrl;
        idOut.stall     = stall;
    end

endmodule

/* src/decodeTop.sv */
`timescale 1ns/1ps

module decodeTop import cpuPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] pc4,
    input  instrT       instr,
    input  wbPortT      wb,
    input  hazardSrcT   hazard,
    input  apbReqT      apbReq,
    output idOutT       idOut,
    output apbRspT      apbRsp
);

    logic [4:0]  dbgAddr;
    logic [31:0] dbgData;  // debug read of the register file

    idStage idStage_i (
        .clk     (clk),
        .rstN    (rstN),
        .pc4     (pc4),
        .instr   (instr),
        .wb      (wb),
        .hazard  (hazard),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData),
        .idOut   (idOut)
    );

    regDebugApb regDebugApb_i (
        .clk     (clk),
        .rstN    (rstN),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

endmodule

/* verif/decodeTb.sv */
`timescale 1ns/1ps

module decodeTb
    import cpuPkg::*;
();

    localparam int Cols     = 16;  // words per vector line
    localparam int MaxSteps = 128;

    logic        clk;
    logic        rstN;
    logic [31:0] pc4;
    instrT       instr;
    wbPortT      wb;
    hazardSrcT   hazard;
    apbReqT      apbReq;
    idOutT       idOut;
    apbRspT      apbRsp;

    logic [31:0] vecMem [0:Cols*MaxSteps-1];
    logic [31:0] v [0:Cols-1];  // fields of the current step
    string       testName [0:5] = '{"none", "wbRead", "aluDecode", "controlXfer",
                                    "hazardStall", "apbDebug"};
    int          numSteps;
    int          curTest;
    int          testSteps;
    int          testErrs;
    int          errCount;
    int          passCount;
    int          failCount;
    bit          loaded;

    decodeTop dut_i (
        .clk    (clk),
        .rstN   (rstN),
        .pc4    (pc4),
        .instr  (instr),
        .wb     (wb),
        .hazard (hazard),
        .apbReq (apbReq),
        .idOut  (idOut),
        .apbRsp (apbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic loadVectors();
        for (int k = 0; k < Cols * MaxSteps; k++) begin
            vecMem[k] = '0;
        end
        $readmemh("verif/decodeTestdata.mem", vecMem);
        numSteps = 0;
        while (numSteps < MaxSteps && vecMem[numSteps * Cols] != 0) begin
            numSteps++;  // kind zero ends the list
        end
    endtask

    task automatic fetchStep(input int idx);
        for (int c = 0; c < Cols; c++) begin
            v[c] = vecMem[idx * Cols + c];
        end
    endtask

    task automatic checkValue(input string field, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("ERR %0t %s %s: expected %h, got %h", $time, testName[curTest],
                     field, expVal, actVal);
            errCount++;
            testErrs++;
        end
    endtask

    // decode is combinational, so one cycle per step
    task automatic runDecode();
        @(posedge clk);
        instr  <= instrT'(v[2]);
        pc4    <= v[3];
        wb     <= '{regWrite: v[4][0], addr: v[5][4:0], data: v[6]};
        hazard <= hazardSrcT'(v[7][12:0]);
        @(negedge clk);
        if (v[15][0]) begin
            checkValue("jumpOrBranchPc", v[8], idOut.jumpOrBranchPc);
        end
        if (v[15][1]) begin
            checkValue("regRtOrZero", v[9], idOut.regRtOrZero);
        end
        if (v[15][2]) begin
            checkValue("regRsOrPc4", v[10], idOut.regRsOrPc4);
        end
        if (v[15][3]) begin
            checkValue("immediate", v[11], idOut.immediate);
        end
        if (v[15][4]) begin
            checkValue("regWriteAddr", v[12], {27'd0, idOut.regWriteAddr});
        end
        if (v[15][5]) begin
            checkValue("ctrl", v[13], {17'd0, idOut.ctrl});
        end
        if (v[15][6]) begin
            checkValue("stall", v[14], {31'd0, idOut.stall});
        end
    endtask

    task automatic runApb(input logic isWrite);
        int waits;
        waits = 0;
        @(posedge clk);
        instr  <= '0;
        wb     <= '0;
        hazard <= '0;
        apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: isWrite, paddr: v[2][7:0],
                    pwdata: v[6]};
        @(negedge clk);
        checkValue("setup pready", 32'd0, {31'd0, apbRsp.pready});
        checkValue("setup pslverr", 32'd0, {31'd0, apbRsp.pslverr});
        @(posedge clk);
        apbReq.penable <= 1'b1;  // access phase
        @(negedge clk);
        while (!apbRsp.pready) begin
            waits++;
            @(negedge clk);
        end
        checkValue("wait states", 32'd0, waits);
        checkValue("pslverr", v[14], {31'd0, apbRsp.pslverr});
        if (v[15][1]) begin
            checkValue("prdata", v[9], apbRsp.prdata);
        end
        @(posedge clk);
        apbReq <= '0;
    endtask

    task automatic closeTest();
        if (testErrs == 0) begin
            passCount++;
            $display("test %s: %0d steps, passed", testName[curTest], testSteps);
        end else begin
            failCount++;
            $display("test %s: %0d steps, %0d mismatches, failed", testName[curTest],
                     testSteps, testErrs);
        end
    endtask

    initial begin
        rstN   = 1'b0;
        pc4    = '0;
        instr  = '0;
        wb     = '0;
        hazard = '0;
        apbReq = '0;
        loadVectors();
        loaded = 1'b1;
        if (numSteps == 0) begin
            $display("no test vectors found in verif/decodeTestdata.mem");
        end
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        for (int s = 0; s < numSteps; s++) begin
            fetchStep(s);
            if (v[1] != curTest) begin
                if (curTest != 0) begin
                    closeTest();
                end
                curTest   = v[1];
                testSteps = 0;
                testErrs  = 0;
            end
            case (v[0])
                32'd1: runDecode();
                32'd2: runApb(1'b0);
                32'd3: runApb(1'b1);
                default: begin
                    $display("step %0d has an unknown kind %0h", s, v[0]);
                    errCount++;
                    testErrs++;
                end
            endcase
            testSteps++;
        end
        if (curTest != 0) begin
            closeTest();
        end
        $display("%0d tests passed, %0d failed, %0d mismatches", passCount, failCount,
                 errCount);
        if (errCount == 0 && numSteps > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // apb steps take three cycles, so four per step leaves margin
    initial begin
        int limitCycles;
        wait (loaded);
        limitCycles = numSteps * 4 + 100;
        #(limitCycles * 8);
        $display("timeout: the run did not finish within %0d cycles", limitCycles);
        $display("Errors found");
        $finish;
    end

endmodule

/* verif/decodeTestdata.mem */
// kind test instr|paddr pc4 wbWe wbAddr wbData|pwdata hazard expPc expRt|prdata expRs
// expImm expWa expCtrl expStall|pslverr mask; kind 1 decode, 2 apb read, 3 apb write
// write-back then read, bypass and $0
1 1 00221820 00000000 1 01 11111111 0000 00000000 00000000 11111111 00000000 03 0000 0 56
1 1 00221820 00000000 1 02 22222222 0000 00000000 22222222 11111111 00000000 03 0000 0 56
1 1 00022025 00000000 1 00 deadbeef 0000 00000000 22222222 00000000 00000000 04 0000 0 56
1 1 00012025 00000000 0 00 00000000 0000 00000000 11111111 00000000 00000000 04 0000 0 56
1 1 00a13020 00000000 1 05 80000004 0000 00000000 11111111 80000004 00000000 06 0000 0 56
1 1 00e54022 00000000 1 07 00000010 0000 00000000 80000004 00000010 00000000 08 0000 0 56
1 1 012a0020 00000000 1 09 12345678 0000 00000000 00000000 12345678 00000000 00 0000 0 56
1 1 012a0020 00000000 1 0a 12345678 0000 00000000 12345678 12345678 00000000 00 0000 0 56
1 1 01606026 00000000 1 0b cafef00d 0000 00000000 00000000 cafef00d 00000000 0c 0000 0 56
// alu decode, r-type then i-type
1 2 00226820 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 0420 0 70
1 2 00226822 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 0c20 0 70
1 2 00226824 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 1420 0 70
1 2 00226825 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 1c20 0 70
1 2 00226826 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 2420 0 70
1 2 00226827 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 2c20 0 70
1 2 0022682a 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0d 3420 0 70
1 2 00027100 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0e 3d20 0 70
1 2 00027102 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0e 4520 0 70
1 2 00027103 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 0e 4d20 0 70
1 2 202ffffc 00000000 0 00 00000000 0000 00000000 00000000 00000000 fffffffc 0f 0440 0 78
1 2 282f8000 00000000 0 00 00000000 0000 00000000 00000000 00000000 ffff8000 0f 3440 0 78
1 2 302ff0f0 00000000 0 00 00000000 0000 00000000 00000000 00000000 0000f0f0 0f 1450 0 78
1 2 342f8001 00000000 0 00 00000000 0000 00000000 00000000 00000000 00008001 0f 1c50 0 78
1 2 382fffff 00000000 0 00 00000000 0000 00000000 00000000 00000000 0000ffff 0f 2450 0 78
1 2 8c2f0010 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000010 0f 04c0 0 78
1 2 ac2ffff8 00000000 0 00 00000000 0000 00000000 00000000 00000000 fffffff8 0f 0240 0 78
1 2 fc000000 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 00 0000 0 78
// branches, jumps and jal
1 3 112a0004 00400010 0 00 00000000 0000 00400020 12345678 12345678 00000000 0a 0801 0 77
1 3 112bfffe 00400010 0 00 00000000 0000 00400008 cafef00d 12345678 00000000 0b 0800 0 77
1 3 152b0008 00400010 0 00 00000000 0000 00400030 cafef00d 12345678 00000000 0b 0801 0 77
1 3 152a0008 00400010 0 00 00000000 0000 00400030 12345678 12345678 00000000 0a 0800 0 77
1 3 08100040 90000010 0 00 00000000 0000 90400100 00000000 00000000 00000000 00 0005 0 61
1 3 00e00008 00400010 0 00 00000000 0000 00000010 00000000 00000010 00000000 00 0003 0 77
1 3 0c000100 00400010 0 00 00000000 0000 00000400 00000000 00400010 00000000 1f 040d 0 77
// stalls against EX and MEM
1 4 00221820 00000000 0 00 00000000 10c0 00000000 00000000 00000000 00000000 00 0020 1 60
1 4 00221820 00000000 0 00 00000000 1100 00000000 00000000 00000000 00000000 00 0420 0 60
1 4 112a0004 00000000 0 00 00000000 1500 00000000 00000000 00000000 00000000 00 0800 1 60
1 4 112a0004 00000000 0 00 00000000 0029 00000000 00000000 00000000 00000000 00 0800 1 60
1 4 00022025 00000000 0 00 00000000 1040 00000000 00000000 00000000 00000000 00 1c20 0 60
1 4 00221820 00000000 0 00 00000000 0021 00000000 00000000 00000000 00000000 00 0420 0 60
1 4 00e00008 00000000 0 00 00000000 0027 00000000 00000000 00000000 00000000 00 0002 1 60
1 4 ac2ffff8 00000000 0 00 00000000 17c0 00000000 00000000 00000000 00000000 00 0040 1 60
// apb debug reads, a refused write, then a read back
2 5 00000004 00000000 0 00 00000000 0000 00000000 11111111 00000000 00000000 00 0000 0 02
2 5 000000a4 00000000 0 00 00000000 0000 00000000 12345678 00000000 00000000 00 0000 0 02
2 5 0000002f 00000000 0 00 00000000 0000 00000000 cafef00d 00000000 00000000 00 0000 0 02
2 5 00000000 00000000 0 00 00000000 0000 00000000 00000000 00000000 00000000 00 0000 0 02
3 5 00000004 00000000 0 00 ffffffff 0000 00000000 00000000 00000000 00000000 00 0000 1 00
2 5 00000004 00000000 0 00 00000000 0000 00000000 11111111 00000000 00000000 00 0000 0 02
0

/* list.f */
common/cpuPkg.sv
regFile/regFile.sv
regFile/regDebugApb.sv
idStage/controlUnit.sv
idStage/idStage.sv
src/decodeTop.sv
verif/decodeTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert
TOP       = decodeTb
FILELIST  = list.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the log holds the pass line
sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
